//--- icache_lookup_macros.svh
/*
 * Geometry of the serial instruction-cache lookup. TAG_W is derived and must stay
 * consistent with FETCH_AW, LINE_ALIGN and COUNT_ALIGN. SET_COUNT of 2 is assumed by
 * the one-bit set index.
 */

`ifndef ICACHE_LOOKUP_MACROS_SVH
`define ICACHE_LOOKUP_MACROS_SVH

// Fetch interface
`define ICACHE_FETCH_AW 32
`define ICACHE_ID_W 4

// Line geometry in bits and byte-offset bits
`define ICACHE_LINE_W 128
`define ICACHE_LINE_ALIGN 4

// Lines per set and the index width that addresses them
`define ICACHE_LINE_COUNT 16
`define ICACHE_COUNT_ALIGN 4

// Associativity
`define ICACHE_SET_COUNT 2
`define ICACHE_SET_ALIGN 1

// Tag is what remains of the address above index and offset
`define ICACHE_TAG_W (`ICACHE_FETCH_AW - `ICACHE_LINE_ALIGN - `ICACHE_COUNT_ALIGN)

`endif

//--- icache_pkg.sv
/*
 * Shared types of the serial instruction-cache lookup.
 * Field widths follow the macros header, so both must be compiled together.
 */

`include "icache_lookup_macros.svh"

package icache_pkg;

    // Lookup request as it enters the cache
    typedef struct packed {
        logic [`ICACHE_FETCH_AW-1:0] addr;
        logic [`ICACHE_ID_W-1:0]     id;
    } lookup_req_t;

    // One refill writes tag, error bit and line data of a single set
    typedef struct packed {
        logic [`ICACHE_COUNT_ALIGN-1:0] line;
        logic [`ICACHE_SET_ALIGN-1:0]   cset;
        logic [`ICACHE_TAG_W-1:0]       tag;
        logic                           error;
        logic [`ICACHE_LINE_W-1:0]      data;
    } refill_t;

    // Stored per set and per line in the tag array
    typedef struct packed {
        logic                     valid;
        logic                     error;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [`ICACHE_SET_ALIGN-1:0] cset;
        logic                         hit;
        logic                         error;
    } tag_rsp_t;

    // Handed from the tag stage to the data stage
    typedef struct packed {
        lookup_req_t req;
        tag_rsp_t    rsp;
    } stage_req_t;

    typedef struct packed {
        logic [`ICACHE_FETCH_AW-1:0]  addr;
        logic [`ICACHE_ID_W-1:0]      id;
        logic [`ICACHE_SET_ALIGN-1:0] cset;
        logic                         hit;
        logic                         error;
        logic [`ICACHE_LINE_W-1:0]    data;
    } lookup_rsp_t;

    typedef enum logic [1:0] {
        TAG_OP_IDLE,
        TAG_OP_CLEAR,
        TAG_OP_REFILL,
        TAG_OP_LOOKUP
    } tag_op_e;

    typedef enum logic {
        CLEAR_BUSY,
        CLEAR_DONE
    } clear_state_e;

endpackage

//--- icache_tag_port_ctrl.sv
/*
 * Owns the single port of the tag array. Clearing runs for LINE_COUNT cycles after
 * reset and after each flush strobe, and blocks refills and lookups meanwhile.
 * refill_ready_o is only high while a refill is actually being written.
 */

`timescale 1ns/1ps

`include "icache_lookup_macros.svh"

module icache_tag_port_ctrl import icache_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           flush_valid_i,
    input  logic                           in_valid_i,
    input  logic [`ICACHE_COUNT_ALIGN-1:0] in_line_i,
    input  logic                           refill_valid_i,
    input  logic [`ICACHE_COUNT_ALIGN-1:0] refill_line_i,
    input  logic [`ICACHE_SET_ALIGN-1:0]   refill_set_i,
    input  logic                           stage_free_i,
    output tag_op_e                        tag_op_o,
    output logic [`ICACHE_COUNT_ALIGN-1:0] tag_line_o,
    output logic [`ICACHE_SET_COUNT-1:0]   tag_set_en_o,
    output logic                           in_ready_o,
    output logic                           refill_ready_o
);

    clear_state_e                   clear_state_q;
    logic [`ICACHE_COUNT_ALIGN-1:0] clear_count_q;
    logic                           clear_last;

    assign clear_last = clear_count_q == `ICACHE_COUNT_ALIGN'(`ICACHE_LINE_COUNT - 1);

    // ------------------------------------------------------------------------
    // Clear sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            clear_state_q <= CLEAR_BUSY;
            clear_count_q <= '0;
        end else begin
            case (clear_state_q)
                CLEAR_BUSY: begin
                    clear_count_q <= clear_count_q + 1'b1;
                    if (clear_last) begin
                        clear_state_q <= CLEAR_DONE;
                    end
                end
                default: begin
                    // A flush restarts the sweep from line zero
                    if (flush_valid_i) begin
                        clear_state_q <= CLEAR_BUSY;
                        clear_count_q <= '0;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Port arbitration: clear, then refill, then lookup
    // ------------------------------------------------------------------------
    always_comb begin
        tag_op_o       = TAG_OP_IDLE;
        tag_line_o     = in_line_i;
        tag_set_en_o   = '1;
        in_ready_o     = 1'b0;
        refill_ready_o = 1'b0;

        if (clear_state_q == CLEAR_BUSY) begin
            tag_op_o   = TAG_OP_CLEAR;
            tag_line_o = clear_count_q;
        end else if (refill_valid_i) begin
            tag_op_o                   = TAG_OP_REFILL;
            tag_line_o                 = refill_line_i;
            tag_set_en_o               = '0;
            tag_set_en_o[refill_set_i] = 1'b1;
            refill_ready_o             = 1'b1;
        end else begin
            in_ready_o = stage_free_i;
            if (in_valid_i && stage_free_i) begin
                tag_op_o = TAG_OP_LOOKUP;
            end
        end
    end

endmodule

//--- icache_tag_stage.sv
/*
 * Tag lookup stage with an inferred synchronous-read tag array per set.
 * The response passes straight through in the cycle after the read and is held
 * in a buffer only while the data stage stalls.
 */

`timescale 1ns/1ps

`include "icache_lookup_macros.svh"

module icache_tag_stage import icache_pkg::*; (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  tag_op_e                        tag_op_i,
    input  logic [`ICACHE_COUNT_ALIGN-1:0] tag_line_i,
    input  logic [`ICACHE_SET_COUNT-1:0]   tag_set_en_i,
    input  lookup_req_t                    in_req_i,
    input  refill_t                        refill_i,
    input  logic                           stage_ready_i,
    output logic                           stage_free_o,
    output stage_req_t                     stage_req_o,
    output logic                           stage_valid_o
);

    tag_entry_t                     tag_mem [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
    tag_entry_t                     tag_rdata_q [`ICACHE_SET_COUNT];
    tag_entry_t                     tag_wdata;
    logic                           tag_write;
    logic                           tag_read;

    lookup_req_t                    req_q;
    logic                           valid_q;
    logic                           lookup_q;

    logic [`ICACHE_TAG_W-1:0]       required_tag;
    logic [`ICACHE_SET_COUNT-1:0]   line_hit;
    tag_rsp_t                       rsp_s;
    tag_rsp_t                       rsp_d;
    tag_rsp_t                       rsp_q;
    tag_rsp_t                       rsp;

    // ------------------------------------------------------------------------
    // Tag array
    // ------------------------------------------------------------------------
    assign tag_write = (tag_op_i == TAG_OP_CLEAR) || (tag_op_i == TAG_OP_REFILL);
    assign tag_read  = tag_op_i == TAG_OP_LOOKUP;

    // Clearing writes an all-zero entry, which is invalid
    assign tag_wdata = (tag_op_i == TAG_OP_REFILL) ? {1'b1, refill_i.error, refill_i.tag} : '0;

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `ICACHE_SET_COUNT; i++) begin
            if (tag_set_en_i[i]) begin
                if (tag_write) begin
                    tag_mem[i][tag_line_i] <= tag_wdata;
                end else if (tag_read) begin
                    tag_rdata_q[i] <= tag_mem[i][tag_line_i];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (tag_read) begin
            req_q <= in_req_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            lookup_q <= 1'b0;
            rsp_q    <= '0;
        end else begin
            lookup_q <= tag_read;
            rsp_q    <= rsp_d;
            if (tag_read) begin
                valid_q <= 1'b1;
            end else if (stage_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Empty, or the data stage takes the current entry this cycle
    assign stage_free_o = !valid_q || stage_ready_i;

    // ------------------------------------------------------------------------
    // Hit check
    // ------------------------------------------------------------------------
    assign required_tag = req_q.addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_W];

    always_comb begin
        for (int i = 0; i < `ICACHE_SET_COUNT; i++) begin
            line_hit[i] = tag_rdata_q[i].valid && (tag_rdata_q[i].tag == required_tag);
        end

        // Walk downwards so the lowest hitting set wins
        rsp_s.cset = '0;
        for (int i = `ICACHE_SET_COUNT - 1; i >= 0; i--) begin
            if (line_hit[i]) begin
                rsp_s.cset = `ICACHE_SET_ALIGN'(i);
            end
        end
        rsp_s.hit   = |line_hit;
        rsp_s.error = rsp_s.hit && tag_rdata_q[rsp_s.cset].error;
    end

    // Fresh read data right after a lookup, the buffer otherwise
    assign rsp = lookup_q ? rsp_s : rsp_q;

    always_comb begin
        rsp_d = rsp_q;
        if (lookup_q && !stage_ready_i) begin
            rsp_d = rsp_s;
        end
        // A refill into the buffered line replaces its data, so the hit is stale
        if ((tag_op_i == TAG_OP_REFILL) && (refill_i.cset == rsp.cset) &&
            (refill_i.line == req_q.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN])) begin
            rsp_d.hit = 1'b0;
        end
    end

    assign stage_req_o.req = req_q;
    assign stage_req_o.rsp = rsp;
    assign stage_valid_o   = valid_q;

endmodule

//--- icache_data_stage.sv
/*
 * Data stage with an inferred single-port line array indexed by set and line.
 * A refill write owns the port and blocks the stage handshake in that cycle.
 * The line data of a miss response is undefined.
 */

`timescale 1ns/1ps

`include "icache_lookup_macros.svh"

module icache_data_stage import icache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        refill_write_i,
    input  refill_t     refill_i,
    input  stage_req_t  stage_req_i,
    input  logic        stage_valid_i,
    input  logic        out_ready_i,
    output logic        stage_ready_o,
    output lookup_rsp_t out_rsp_o,
    output logic        out_valid_o
);

    localparam int unsigned DataAddrW = `ICACHE_SET_ALIGN + `ICACHE_COUNT_ALIGN;
    localparam int unsigned DataDepth = `ICACHE_SET_COUNT * `ICACHE_LINE_COUNT;

    logic [`ICACHE_LINE_W-1:0] data_mem [DataDepth];
    logic [DataAddrW-1:0]      read_addr;
    logic [DataAddrW-1:0]      write_addr;
    logic [`ICACHE_LINE_W-1:0] rdata_q;
    logic [`ICACHE_LINE_W-1:0] line_q;
    logic                      read_en;
    logic                      read_q;

    stage_req_t                meta_q;
    logic                      out_valid_q;
    logic                      handshake;

    // ------------------------------------------------------------------------
    // Handshake with the tag stage
    // ------------------------------------------------------------------------
    assign stage_ready_o = (!out_valid_q || out_ready_i) && !refill_write_i;
    assign handshake     = stage_valid_i && stage_ready_o;

    // Misses skip the array read
    assign read_en = handshake && stage_req_i.rsp.hit;

    assign read_addr  = {stage_req_i.rsp.cset,
                         stage_req_i.req.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN]};
    assign write_addr = {refill_i.cset, refill_i.line};

    // ------------------------------------------------------------------------
    // Data array
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (refill_write_i) begin
            data_mem[write_addr] <= refill_i.data;
        end else if (read_en) begin
            rdata_q <= data_mem[read_addr];
        end
    end

    // ------------------------------------------------------------------------
    // Output register and fall-through buffer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (handshake) begin
            meta_q <= stage_req_i;
        end
        // Keep the line if it arrives while the consumer stalls
        if (read_q && !out_ready_i) begin
            line_q <= rdata_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q <= 1'b0;
            read_q      <= 1'b0;
        end else begin
            read_q <= read_en;
            if (handshake) begin
                out_valid_q <= 1'b1;
            end else if (out_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    assign out_rsp_o.addr  = meta_q.req.addr;
    assign out_rsp_o.id    = meta_q.req.id;
    assign out_rsp_o.cset  = meta_q.rsp.cset;
    assign out_rsp_o.hit   = meta_q.rsp.hit;
    assign out_rsp_o.error = meta_q.rsp.error;
    assign out_rsp_o.data  = read_q ? rdata_q : line_q;
    assign out_valid_o     = out_valid_q;

endmodule

//--- icache_lookup_serial.sv
/*
 * Two-stage serial instruction-cache lookup. At most two lookups are in flight
 * and responses leave in request order. No request or refill is taken for
 * LINE_COUNT cycles after reset or a flush.
 */

`timescale 1ns/1ps

`include "icache_lookup_macros.svh"

module icache_lookup_serial import icache_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        flush_valid_i,
    input  lookup_req_t in_req_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,
    input  refill_t     refill_i,
    input  logic        refill_valid_i,
    output logic        refill_ready_o,
    output lookup_rsp_t out_rsp_o,
    output logic        out_valid_o,
    input  logic        out_ready_i
);

    tag_op_e                        tag_op;
    logic [`ICACHE_COUNT_ALIGN-1:0] tag_line;
    logic [`ICACHE_SET_COUNT-1:0]   tag_set_en;
    logic                           stage_free;
    stage_req_t                     stage_req;
    logic                           stage_valid;
    logic                           stage_ready;

    // refill_ready_o is high exactly when a refill is written, so it doubles as
    // the data-array write strobe
    icache_tag_port_ctrl i_tag_port_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_valid_i  (flush_valid_i),
        .in_valid_i     (in_valid_i),
        .in_line_i      (in_req_i.addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN]),
        .refill_valid_i (refill_valid_i),
        .refill_line_i  (refill_i.line),
        .refill_set_i   (refill_i.cset),
        .stage_free_i   (stage_free),
        .tag_op_o       (tag_op),
        .tag_line_o     (tag_line),
        .tag_set_en_o   (tag_set_en),
        .in_ready_o     (in_ready_o),
        .refill_ready_o (refill_ready_o)
    );

    icache_tag_stage i_tag_stage (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .tag_op_i      (tag_op),
        .tag_line_i    (tag_line),
        .tag_set_en_i  (tag_set_en),
        .in_req_i      (in_req_i),
        .refill_i      (refill_i),
        .stage_ready_i (stage_ready),
        .stage_free_o  (stage_free),
        .stage_req_o   (stage_req),
        .stage_valid_o (stage_valid)
    );

    icache_data_stage i_data_stage (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .refill_write_i (refill_ready_o),
        .refill_i       (refill_i),
        .stage_req_i    (stage_req),
        .stage_valid_i  (stage_valid),
        .out_ready_i    (out_ready_i),
        .stage_ready_o  (stage_ready),
        .out_rsp_o      (out_rsp_o),
        .out_valid_o    (out_valid_o)
    );

endmodule

//--- tb_icache_lookup_serial.sv
/*
 * Testbench for the serial instruction-cache lookup. Refills are issued only
 * while no lookup is in flight, so expected responses are fixed at acceptance.
 * Line data is compared on hits only.
 */

`timescale 1ns/1ps

`include "icache_lookup_macros.svh"

module tb_icache_lookup_serial import icache_pkg::*; ();

    typedef logic [`ICACHE_TAG_W-1:0] tag_t;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]  tag;
        logic                      error;
        logic [`ICACHE_LINE_W-1:0] data;
    } entry_t;

    localparam int NumTests = 6;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        flush_valid_i;
    lookup_req_t in_req_i;
    logic        in_valid_i;
    logic        in_ready_o;
    refill_t     refill_i;
    logic        refill_valid_i;
    logic        refill_ready_o;
    lookup_rsp_t out_rsp_o;
    logic        out_valid_o;
    logic        out_ready_i;

    logic [31:0]   lfsr_q = 32'h09ca_4b36;
    entry_t        model [int];
    lookup_rsp_t   exp_q [$];
    logic [31:0]   known_q [$];
    lookup_rsp_t   exp_rsp;
    lookup_rsp_t   prev_rsp;
    logic          prev_stall = 1'b0;
    logic          bp_en = 1'b0;
    int            errors = 0;
    int            test_errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    icache_lookup_serial i_icache_lookup_serial (.*);

    always #10 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(logic [`ICACHE_TAG_W-1:0] tag, logic [3:0] idx);
        logic [31:0] r;
        r = rand_bits(`ICACHE_LINE_ALIGN);
        return {tag, idx, r[`ICACHE_LINE_ALIGN-1:0]};
    endfunction

    // Lowest valid set with a matching tag hits
    function automatic lookup_rsp_t expect_for(logic [31:0] addr, logic [3:0] id);
        lookup_rsp_t r;
        int          key;
        r = '0;
        r.addr = addr;
        r.id   = id;
        for (int s = `ICACHE_SET_COUNT - 1; s >= 0; s--) begin
            key = addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN] * `ICACHE_SET_COUNT + s;
            if (model.exists(key) && model[key].tag == addr[31 -: `ICACHE_TAG_W]) begin
                r.hit   = 1'b1;
                r.cset  = 1'(s);
                r.error = model[key].error;
                r.data  = model[key].data;
            end
        end
        return r;
    endfunction

    function automatic bit same_rsp(lookup_rsp_t a, lookup_rsp_t b);
        if (a.addr !== b.addr || a.id !== b.id || a.hit !== b.hit) return 1'b0;
        if (b.hit && (a.cset !== b.cset || a.error !== b.error || a.data !== b.data)) return 1'b0;
        return 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Output monitor sampled at the falling edge where everything has settled
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (prev_stall) begin
                assert (out_valid_o && same_rsp(out_rsp_o, prev_rsp)) else begin
                    errors++;
                    $display("FAIL %0t: response changed while stalled", $time);
                end
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Response for addr %h came with no request outstanding",
                             out_rsp_o.addr);
                end else begin
                    exp_rsp = exp_q.pop_front();
                    assert (same_rsp(out_rsp_o, exp_rsp)) else begin
                        errors++;
                        $display("FAIL %0t: got addr %h id %h hit %b set %b, expected %h %h %b %b",
                                 $time, out_rsp_o.addr, out_rsp_o.id, out_rsp_o.hit,
                                 out_rsp_o.cset, exp_rsp.addr, exp_rsp.id, exp_rsp.hit,
                                 exp_rsp.cset);
                    end
                end
            end
            prev_stall = out_valid_o && !out_ready_i;
            prev_rsp   = out_rsp_o;
        end
    end

    always @(posedge clk_i) begin
        #1;
        out_ready_i = bp_en ? lfsr_step() : 1'b1;
    end

    initial begin
        #(NumTests * 2000 * 20);
        $display("Watchdog expired, the DUT stopped responding");
        $display("Test failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic send_lookup(logic [31:0] addr);
        in_req_i.addr = addr;
        in_req_i.id   = `ICACHE_ID_W'(rand_bits(`ICACHE_ID_W));
        in_valid_i    = 1'b1;
        do @(negedge clk_i); while (!in_ready_o);
        exp_q.push_back(expect_for(addr, in_req_i.id));
        @(posedge clk_i);
        #1 in_valid_i = 1'b0;
    endtask

    // Present a refill with random error bit and line data
    task automatic start_refill(logic [3:0] idx, logic set, tag_t tag);
        refill_i.line  = idx;
        refill_i.cset  = set;
        refill_i.tag   = tag;
        refill_i.error = lfsr_step();
        refill_i.data  = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        refill_valid_i = 1'b1;
    endtask

    // The refill is written at the coming edge
    task automatic end_refill();
        model[refill_i.line * `ICACHE_SET_COUNT + refill_i.cset] =
            '{refill_i.tag, refill_i.error, refill_i.data};
        known_q.push_back(make_addr(refill_i.tag, refill_i.line));
        @(posedge clk_i);
        #1 refill_valid_i = 1'b0;
    endtask

    task automatic do_refill(logic [3:0] idx, logic set, tag_t tag);
        start_refill(idx, set, tag);
        do @(negedge clk_i); while (!refill_ready_o);
        end_refill();
    endtask

    task automatic wait_drain();
        do @(negedge clk_i); while (exp_q.size() != 0 || out_valid_o);
        @(posedge clk_i);
        #1;
    endtask

    // Both ready outputs must stay low while the tag lines are cleared, even
    // with a refill pending, and the refill goes first once clearing ends
    task automatic check_blocked();
        start_refill(4'(rand_bits(4)), lfsr_step(), tag_t'(rand_bits(`ICACHE_TAG_W)));
        repeat (`ICACHE_LINE_COUNT) begin
            @(negedge clk_i);
            assert (!in_ready_o && !refill_ready_o) else begin
                errors++;
                $display("FAIL %0t: ready high during tag clear", $time);
            end
        end
        @(negedge clk_i);
        assert (refill_ready_o) else begin
            errors++;
            $display("FAIL %0t: refill_ready_o still low after tag clear", $time);
        end
        end_refill();
        @(negedge clk_i);
        assert (in_ready_o) else begin
            errors++;
            $display("FAIL %0t: in_ready_o still low after tag clear", $time);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == test_errors) ? "ok" : "errors");
        test_errors = errors;
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    initial begin
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [3:0]               idx;
        rst_ni         = 1'b0;
        flush_valid_i  = 1'b0;
        in_req_i       = '0;
        in_valid_i     = 1'b0;
        refill_i       = '0;
        refill_valid_i = 1'b0;
        out_ready_i    = 1'b1;
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        check_blocked();
        repeat (8) send_lookup(rand_bits(32));
        wait_drain();
        finish_test("after reset");

        repeat (4) do_refill(4'(rand_bits(4)), lfsr_step(), tag_t'(rand_bits(`ICACHE_TAG_W)));
        foreach (known_q[i]) send_lookup(known_q[i]);
        wait_drain();
        finish_test("refill then lookup");

        idx = 4'(rand_bits(4));
        tag = tag_t'(rand_bits(`ICACHE_TAG_W));
        do_refill(idx, 1'b0, tag);
        do_refill(idx, 1'b1, tag ^ 24'h1);
        send_lookup(make_addr(tag, idx));
        send_lookup(make_addr(tag ^ 24'h1, idx));
        send_lookup(make_addr(tag ^ 24'h2, idx));
        wait_drain();
        finish_test("two sets");

        bp_en = 1'b1;
        repeat (40) begin
            if (lfsr_step()) send_lookup(known_q[rand_bits(8) % known_q.size()]);
            else send_lookup(rand_bits(32));
        end
        wait_drain();
        bp_en = 1'b0;
        finish_test("back-pressure");

        idx = 4'(rand_bits(4));
        tag = tag_t'(rand_bits(`ICACHE_TAG_W));
        start_refill(idx, 1'b0, tag);
        in_req_i.addr  = make_addr(tag, idx);
        in_req_i.id    = `ICACHE_ID_W'(rand_bits(`ICACHE_ID_W));
        in_valid_i     = 1'b1;
        @(negedge clk_i);
        assert (refill_ready_o && !in_ready_o) else begin
            errors++;
            $display("FAIL %0t: refill did not take priority over lookup", $time);
        end
        end_refill();
        do @(negedge clk_i); while (!in_ready_o);
        exp_q.push_back(expect_for(in_req_i.addr, in_req_i.id));
        @(posedge clk_i);
        #1 in_valid_i = 1'b0;
        wait_drain();
        finish_test("refill priority");

        flush_valid_i = 1'b1;
        @(posedge clk_i);
        #1 flush_valid_i = 1'b0;
        model.delete();
        check_blocked();
        foreach (known_q[i]) send_lookup(known_q[i]);
        wait_drain();
        finish_test("flush");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- icache_lookup_serial.f
+incdir+.
icache_pkg.sv
icache_tag_port_ctrl.sv
icache_tag_stage.sv
icache_data_stage.sv
icache_lookup_serial.sv
tb_icache_lookup_serial.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lookup testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_icache_lookup_serial \
    -Mdir obj_dir \
    -f icache_lookup_serial.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/Vtb_icache_lookup_serial > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" sim.log; then
    exit 0
fi
exit 1
